//--- sdram_cfg_pkg.sv
`default_nettype none

package sdram_cfg_pkg;

    // widths that carry a meaning
    typedef logic [22:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  bank_t;
    typedef logic [12:0] row_t;
    typedef logic [7:0]  col_t;
    typedef logic [12:0] pin_addr_t;
    typedef logic [7:0]  delay_t;
    typedef logic [9:0]  refresh_cnt_t;

    // user address split: row | bank | column
    localparam int BANK_LSB = 8;
    localparam int BANK_MSB = 9;
    localparam int ROW_LSB  = 10;
    localparam int COL_MSB  = 7;

    localparam int NUM_BANKS = 4;

    // reserved, burst access, standard op, cas 2, sequential, burst 4
    localparam pin_addr_t MODE_WORD = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b010};

    // extra wait cycles after each command
    localparam delay_t T_CAS_DEF = 8'd2;
    localparam delay_t T_PRE_DEF = 8'd2;
    localparam delay_t T_ACT_DEF = 8'd2;
    localparam delay_t T_REF_DEF = 8'd6;

    localparam refresh_cnt_t REFRESH_INTERVAL_DEF = 10'd750;

endpackage

`default_nettype wire

//--- sdram_cmd_pkg.sv
`default_nettype none

package sdram_cmd_pkg;

    // bits are {cs, ras, cas, we}
    typedef enum logic [3:0] {
        CMD_DESELECT  = 4'b1000,
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_IDLE,
        ST_WAIT,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_READ_RES,
        ST_WRITE,
        ST_PRECHARGE
    } seq_state_e;

    typedef struct packed {
        logic                 write;
        sdram_cfg_pkg::addr_t addr;
        sdram_cfg_pkg::data_t data;
    } user_req_t;

    // one command as the sequencer issues it
    typedef struct packed {
        sdram_cmd_e               cmd;
        sdram_cfg_pkg::bank_t     bank;
        sdram_cfg_pkg::pin_addr_t addr;
        sdram_cfg_pkg::data_t     wdata;
        logic                     write;
    } sdram_cmd_t;

    typedef struct packed {
        logic                     cke;
        logic                     cs;
        logic                     ras;
        logic                     cas;
        logic                     we;
        sdram_cfg_pkg::bank_t     bank;
        sdram_cfg_pkg::pin_addr_t addr;
    } sdram_pins_t;

endpackage

`default_nettype wire

//--- sdram_request_queue.sv
`default_nettype none

module sdram_request_queue (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    in_valid,
    input  wire logic                    rw,
    input  wire sdram_cfg_pkg::addr_t    user_addr,
    input  wire sdram_cfg_pkg::data_t    data_in,
    input  wire logic                    req_release,
    output sdram_cmd_pkg::user_req_t     pending_req,
    output logic                         pending,
    output logic                         busy
);

    logic full;

    // comes out of reset full, emptied by the first release after init
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b1;
        end else if (req_release) begin
            full <= 1'b0;
        end else if (in_valid && !full) begin
            full <= 1'b1;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (in_valid && !full) begin
            pending_req.write <= rw;
            pending_req.addr  <= user_addr;
            pending_req.data  <= data_in;
        end
    end

    assign pending = full;
    assign busy    = full;

endmodule

`default_nettype wire

//--- sdram_bank_tracker.sv
`default_nettype none

module sdram_bank_tracker (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 activate,
    input  wire logic                 precharge,
    input  wire logic                 precharge_all,
    input  wire sdram_cfg_pkg::bank_t cmd_bank,
    input  wire sdram_cfg_pkg::row_t  cmd_row,
    input  wire sdram_cfg_pkg::bank_t query_bank,
    input  wire sdram_cfg_pkg::row_t  query_row,
    output logic                      bank_open,
    output logic                      row_hit
);

    import sdram_cfg_pkg::*;

    logic [NUM_BANKS-1:0] open_flag;
    row_t                 open_row [NUM_BANKS];

    always_ff @(posedge clk) begin
        if (rst) begin
            open_flag <= '0;
        end else begin
            if (precharge) begin
                if (precharge_all) begin
                    open_flag <= '0;
                end else begin
                    open_flag[cmd_bank] <= 1'b0;
                end
            end
            if (activate) begin
                open_flag[cmd_bank] <= 1'b1;
            end
        end
    end

    // row table, only meaningful while the flag is set
    always_ff @(posedge clk) begin
        if (activate) begin
            open_row[cmd_bank] <= cmd_row;
        end
    end

    assign bank_open = open_flag[query_bank];
    assign row_hit   = bank_open && (open_row[query_bank] == query_row);

endmodule

`default_nettype wire

//--- sdram_timer.sv
`default_nettype none

module sdram_timer #(
    parameter sdram_cfg_pkg::refresh_cnt_t refresh_interval = sdram_cfg_pkg::REFRESH_INTERVAL_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  delay_load,
    input  wire sdram_cfg_pkg::delay_t delay_value,
    output logic                       delay_done,
    input  wire logic                  refresh_ack,
    output logic                       refresh_due
);

    import sdram_cfg_pkg::*;

    localparam refresh_cnt_t refresh_last = refresh_interval - 1'b1;

    delay_t       delay_cnt;
    refresh_cnt_t refresh_cnt;

    //////////////////////////////
    // command wait
    //////////////////////////////

    // counts down to zero and parks there
    always_ff @(posedge clk) begin
        if (rst) begin
            delay_cnt <= '0;
        end else if (delay_load) begin
            delay_cnt <= delay_value;
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    assign delay_done = (delay_cnt == '0);

    //////////////////////////////
    // refresh interval
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            refresh_due <= 1'b0;
        end else if (refresh_cnt == refresh_last) begin
            // a new interval wins over a late ack
            refresh_cnt <= '0;
            refresh_due <= 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (refresh_ack) begin
                refresh_due <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sdram_sequencer.sv
`default_nettype none

module sdram_sequencer #(
    parameter sdram_cfg_pkg::delay_t t_cas = sdram_cfg_pkg::T_CAS_DEF,
    parameter sdram_cfg_pkg::delay_t t_pre = sdram_cfg_pkg::T_PRE_DEF,
    parameter sdram_cfg_pkg::delay_t t_act = sdram_cfg_pkg::T_ACT_DEF,
    parameter sdram_cfg_pkg::delay_t t_ref = sdram_cfg_pkg::T_REF_DEF
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      pending,
    input  wire sdram_cmd_pkg::user_req_t  pending_req,
    output logic                           req_release,
    input  wire logic                      bank_open,
    input  wire logic                      row_hit,
    output logic                           activate,
    output logic                           precharge,
    output logic                           precharge_all,
    output sdram_cfg_pkg::bank_t           cmd_bank,
    output logic                           delay_load,
    output sdram_cfg_pkg::delay_t          delay_value,
    input  wire logic                      delay_done,
    input  wire logic                      refresh_due,
    output logic                           refresh_ack,
    output sdram_cmd_pkg::sdram_cmd_t      next_cmd,
    output logic                           capture
);

    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;

    seq_state_e state, state_d;
    seq_state_e next_state, next_state_d;
    user_req_t  req, req_d;
    logic       pre_all, pre_all_d;
    row_t       req_row;
    col_t       req_col;

    assign cmd_bank = req.addr[BANK_MSB:BANK_LSB];
    assign req_row  = req.addr[ROW_LSB +: $bits(row_t)];
    assign req_col  = req.addr[COL_MSB:0];

    always_comb begin
        state_d       = state;
        next_state_d  = next_state;
        req_d         = req;
        pre_all_d     = pre_all;
        next_cmd      = '{cmd: CMD_NOP, bank: '0, addr: '0, wdata: '0, write: 1'b0};
        req_release   = 1'b0;
        activate      = 1'b0;
        precharge     = 1'b0;
        precharge_all = 1'b0;
        delay_load    = 1'b0;
        delay_value   = '0;
        refresh_ack   = 1'b0;
        capture       = 1'b0;
        case (state)
            ST_INIT: begin
                next_cmd.cmd  = CMD_LOAD_MODE;
                next_cmd.addr = MODE_WORD;
                req_release   = 1'b1;
                state_d       = ST_IDLE;
            end
            ST_IDLE: begin
                // refresh always goes ahead of a waiting request
                if (refresh_due) begin
                    refresh_ack  = 1'b1;
                    pre_all_d    = 1'b1;
                    state_d      = ST_PRECHARGE;
                    next_state_d = ST_REFRESH;
                end else if (pending) begin
                    req_release = 1'b1;
                    req_d       = pending_req;
                    if (!bank_open) begin
                        state_d = ST_ACTIVATE;
                    end else if (row_hit) begin
                        state_d = pending_req.write ? ST_WRITE : ST_READ;
                    end else begin
                        pre_all_d    = 1'b0;
                        state_d      = ST_PRECHARGE;
                        next_state_d = ST_ACTIVATE;
                    end
                end
            end
            ST_WAIT: begin
                if (delay_done) begin
                    state_d = next_state;
                end
            end
            ST_PRECHARGE: begin
                next_cmd.cmd      = CMD_PRECHARGE;
                next_cmd.bank     = pre_all ? '0 : cmd_bank;
                next_cmd.addr[10] = pre_all;
                precharge         = 1'b1;
                precharge_all     = pre_all;
                delay_load        = 1'b1;
                delay_value       = t_pre;
                state_d           = ST_WAIT;
            end
            ST_REFRESH: begin
                next_cmd.cmd = CMD_REFRESH;
                delay_load   = 1'b1;
                delay_value  = t_ref;
                state_d      = ST_WAIT;
                next_state_d = ST_IDLE;
            end
            ST_ACTIVATE: begin
                next_cmd.cmd  = CMD_ACTIVE;
                next_cmd.bank = cmd_bank;
                next_cmd.addr = req_row;
                activate      = 1'b1;
                delay_load    = 1'b1;
                delay_value   = t_act;
                state_d       = ST_WAIT;
                next_state_d  = req.write ? ST_WRITE : ST_READ;
            end
            ST_READ: begin
                next_cmd.cmd  = CMD_READ;
                next_cmd.bank = cmd_bank;
                next_cmd.addr = {3'b000, req_col, 2'b00};
                delay_load    = 1'b1;
                delay_value   = t_cas;
                state_d       = ST_WAIT;
                next_state_d  = ST_READ_RES;
            end
            ST_READ_RES: begin
                capture = 1'b1;
                state_d = ST_IDLE;
            end
            ST_WRITE: begin
                next_cmd.cmd   = CMD_WRITE;
                next_cmd.bank  = cmd_bank;
                next_cmd.addr  = {3'b000, req_col, 2'b00};
                next_cmd.wdata = req.data;
                next_cmd.write = 1'b1;
                state_d        = ST_IDLE;
            end
            default: state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_INIT;
            next_state <= ST_IDLE;
            pre_all    <= 1'b0;
        end else begin
            state      <= state_d;
            next_state <= next_state_d;
            pre_all    <= pre_all_d;
        end
    end

    // latched request, payload only
    always_ff @(posedge clk) begin
        req <= req_d;
    end

endmodule

`default_nettype wire

//--- sdram_pin_driver.sv
`default_nettype none

module sdram_pin_driver (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire sdram_cmd_pkg::sdram_cmd_t  next_cmd,
    input  wire logic                       capture,
    input  wire sdram_cfg_pkg::data_t       sdram_dqi,
    output sdram_cmd_pkg::sdram_pins_t      pins,
    output sdram_cfg_pkg::data_t            sdram_dqo,
    output sdram_cfg_pkg::data_t            data_out,
    output logic                            out_valid
);

    import sdram_cmd_pkg::*;

    // pins follow the sequencer by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pins.cke                                <= 1'b0;
            {pins.cs, pins.ras, pins.cas, pins.we}  <= CMD_NOP;
            pins.bank                               <= '0;
            pins.addr                               <= '0;
            sdram_dqo                               <= '0;
            out_valid                               <= 1'b0;
        end else begin
            pins.cke                                <= 1'b1;
            {pins.cs, pins.ras, pins.cas, pins.we}  <= next_cmd.cmd;
            pins.bank                               <= next_cmd.bank;
            pins.addr                               <= next_cmd.addr;
            // data bus quiet except in the write cycle
            sdram_dqo                               <= next_cmd.write ? next_cmd.wdata : '0;
            out_valid                               <= capture;
        end
    end

    // read data, held until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            data_out <= sdram_dqi;
        end
    end

endmodule

`default_nettype wire

//--- sdram_ctrl_top.sv
`default_nettype none

module sdram_ctrl_top #(
    parameter sdram_cfg_pkg::delay_t       t_cas            = sdram_cfg_pkg::T_CAS_DEF,
    parameter sdram_cfg_pkg::delay_t       t_pre            = sdram_cfg_pkg::T_PRE_DEF,
    parameter sdram_cfg_pkg::delay_t       t_act            = sdram_cfg_pkg::T_ACT_DEF,
    parameter sdram_cfg_pkg::delay_t       t_ref            = sdram_cfg_pkg::T_REF_DEF,
    parameter sdram_cfg_pkg::refresh_cnt_t refresh_interval = sdram_cfg_pkg::REFRESH_INTERVAL_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire sdram_cfg_pkg::addr_t  user_addr,
    input  wire logic                  rw,
    input  wire sdram_cfg_pkg::data_t  data_in,
    input  wire logic                  in_valid,
    input  wire sdram_cfg_pkg::data_t  sdram_dqi,
    output sdram_cfg_pkg::data_t       data_out,
    output logic                       busy,
    output logic                       out_valid,
    output sdram_cmd_pkg::sdram_pins_t pins,
    output sdram_cfg_pkg::data_t       sdram_dqo
);

    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;

    user_req_t  pending_req;
    logic       pending;
    logic       req_release;
    logic       bank_open;
    logic       row_hit;
    logic       activate;
    logic       precharge;
    logic       precharge_all;
    bank_t      cmd_bank;
    logic       delay_load;
    delay_t     delay_value;
    logic       delay_done;
    logic       refresh_due;
    logic       refresh_ack;
    sdram_cmd_t next_cmd;
    logic       capture;

    sdram_request_queue u_queue (
        .clk(clk), .rst(rst), .in_valid(in_valid), .rw(rw), .user_addr(user_addr),
        .data_in(data_in), .req_release(req_release), .pending_req(pending_req),
        .pending(pending), .busy(busy)
    );

    // row for an activate rides on the command's pin address
    sdram_bank_tracker u_banks (
        .clk(clk), .rst(rst), .activate(activate), .precharge(precharge),
        .precharge_all(precharge_all), .cmd_bank(cmd_bank), .cmd_row(next_cmd.addr),
        .query_bank(pending_req.addr[BANK_MSB:BANK_LSB]),
        .query_row(pending_req.addr[ROW_LSB +: $bits(row_t)]),
        .bank_open(bank_open), .row_hit(row_hit)
    );

    sdram_timer #(.refresh_interval(refresh_interval)) u_timer (
        .clk(clk), .rst(rst), .delay_load(delay_load), .delay_value(delay_value),
        .delay_done(delay_done), .refresh_ack(refresh_ack), .refresh_due(refresh_due)
    );

    sdram_sequencer #(.t_cas(t_cas), .t_pre(t_pre), .t_act(t_act), .t_ref(t_ref)) u_seq (
        .clk(clk), .rst(rst), .pending(pending), .pending_req(pending_req),
        .req_release(req_release), .bank_open(bank_open), .row_hit(row_hit),
        .activate(activate), .precharge(precharge), .precharge_all(precharge_all),
        .cmd_bank(cmd_bank), .delay_load(delay_load), .delay_value(delay_value),
        .delay_done(delay_done), .refresh_due(refresh_due), .refresh_ack(refresh_ack),
        .next_cmd(next_cmd), .capture(capture)
    );

    sdram_pin_driver u_pins (
        .clk(clk), .rst(rst), .next_cmd(next_cmd), .capture(capture),
        .sdram_dqi(sdram_dqi), .pins(pins), .sdram_dqo(sdram_dqo),
        .data_out(data_out), .out_valid(out_valid)
    );

endmodule

`default_nettype wire

//--- sdram_ctrl_assertions.sv
`default_nettype none

module sdram_ctrl_assertions (
    input wire logic                       clk,
    input wire logic                       rst,
    input wire logic                       in_valid,
    input wire logic                       busy,
    input wire logic                       out_valid,
    input wire sdram_cmd_pkg::sdram_pins_t pins,
    input wire sdram_cfg_pkg::data_t       sdram_dqo
);

    import sdram_cmd_pkg::*;

    sdram_cmd_e pin_cmd;

    assign pin_cmd = sdram_cmd_e'({pins.cs, pins.ras, pins.cas, pins.we});

    // one pulse per read
    out_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high on two cycles in a row");

    accept_sets_busy: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !busy) |=> busy)
        else $error("busy low after an accepted request");

    reset_nop: assert property (@(posedge clk) rst |=> (pin_cmd == CMD_NOP))
        else $error("pins not NOP during reset");

    // data bus only carries the write word
    dqo_quiet: assert property (@(posedge clk) disable iff (rst)
        (pin_cmd != CMD_WRITE) |-> (sdram_dqo == '0))
        else $error("sdram_dqo driven outside a WRITE");

endmodule

bind sdram_ctrl_top sdram_ctrl_assertions u_checks (
    .clk(clk), .rst(rst), .in_valid(in_valid), .busy(busy), .out_valid(out_valid),
    .pins(pins), .sdram_dqo(sdram_dqo)
);

`default_nettype wire

//--- tb_sdram_ctrl.sv
`default_nettype none

module tb_sdram_ctrl;

    import sdram_cfg_pkg::*;
    import sdram_cmd_pkg::*;

    localparam int timeout_cycles = 200;

    // step flags
    localparam logic [4:0] rnd_addr     = 5'b00001;
    localparam logic [4:0] stray_strobe = 5'b00010;
    localparam logic [4:0] expect_hit   = 5'b00100;
    localparam logic [4:0] expect_miss  = 5'b01000;
    localparam logic [4:0] expect_ref   = 5'b10000;

    typedef struct packed {
        logic [2:0] test;
        logic       write;
        logic [4:0] flags;
        logic [7:0] gap;
        addr_t      addr;
        data_t      data;
    } step_t;

    logic        clk;
    logic        rst;
    addr_t       user_addr;
    logic        rw;
    data_t       data_in;
    logic        in_valid;
    data_t       sdram_dqi;
    data_t       data_out;
    logic        busy;
    logic        out_valid;
    sdram_pins_t pins;
    data_t       sdram_dqo;

    int          errors = 0;
    int          act_cnt = 0;
    int          pre_cnt = 0;
    int          refresh_cnt = 0;
    int          wr_cnt = 0;
    logic        first_seen = 1'b0;
    sdram_cmd_e  first_cmd;
    pin_addr_t   first_addr;
    logic [3:0]  open_flags = '0;
    row_t        open_row [4];
    sdram_cmd_e  last_cmd = CMD_NOP;
    logic        last_all = 1'b0;
    data_t       mem [logic [22:0]];
    data_t       shadow [addr_t];
    step_t       steps [$];
    string       names [7] = '{"", "init", "row hit", "row miss", "refresh",
                               "busy strobe", "random mix"};

    sdram_ctrl_top #(.refresh_interval(10'd120)) uut (
        .clk(clk), .rst(rst), .user_addr(user_addr), .rw(rw), .data_in(data_in),
        .in_valid(in_valid), .sdram_dqi(sdram_dqi), .data_out(data_out), .busy(busy),
        .out_valid(out_valid), .pins(pins), .sdram_dqo(sdram_dqo)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic data_t fill_word(logic [22:0] key);
        return {9'd0, key} ^ 32'h6b3d_c0a5;
    endfunction

    function automatic addr_t make_addr(row_t row, bank_t bank, col_t col);
        return {row, bank, col};
    endfunction

    function automatic data_t expected_word(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return fill_word({a[BANK_MSB:BANK_LSB], a[22:ROW_LSB], a[COL_MSB:0]});
    endfunction

    function automatic step_t make_step(int test, bit write, logic [4:0] flags, int gap,
                                        addr_t addr, data_t data);
        return '{test: test[2:0], write: write, flags: flags, gap: gap[7:0],
                 addr: addr, data: data};
    endfunction

    task automatic order_error(string what);
        $display("memory model: %s", what);
        errors++;
    endtask

    //////////////////////////////
    // sdram model
    //////////////////////////////

    always @(posedge clk) begin : memory_model
        sdram_cmd_e  cmd;
        logic [22:0] key;
        cmd = sdram_cmd_e'({pins.cs, pins.ras, pins.cas, pins.we});
        if (!rst) begin
            key = {pins.bank, open_row[pins.bank], pins.addr[9:2]};
            if (!first_seen && cmd != CMD_NOP) begin
                first_seen = 1'b1;
                first_cmd  = cmd;
                first_addr = pins.addr;
            end
            case (cmd)
                CMD_ACTIVE: begin
                    if (open_flags[pins.bank]) order_error("ACTIVATE to a bank already open");
                    open_flags[pins.bank] = 1'b1;
                    open_row[pins.bank]   = pins.addr;
                    act_cnt++;
                end
                CMD_READ: begin
                    if (!open_flags[pins.bank]) order_error("READ from a closed bank");
                    // held until the next read
                    sdram_dqi <= #1 mem.exists(key) ? mem[key] : fill_word(key);
                end
                CMD_WRITE: begin
                    if (!open_flags[pins.bank]) order_error("WRITE to a closed bank");
                    mem[key] = sdram_dqo;
                    wr_cnt++;
                end
                CMD_PRECHARGE: begin
                    if (pins.addr[10]) open_flags = '0;
                    else open_flags[pins.bank] = 1'b0;
                    pre_cnt++;
                end
                CMD_REFRESH: begin
                    if (open_flags != '0) order_error("REFRESH while a bank is open");
                    if (!(last_cmd == CMD_PRECHARGE && last_all)) begin
                        order_error("REFRESH without a precharge of all banks before it");
                    end
                    refresh_cnt++;
                end
                default: ;
            endcase
            if (cmd != CMD_NOP) begin
                last_cmd = cmd;
                last_all = pins.addr[10];
            end
        end
    end

    //////////////////////////////
    // waits and strobes
    //////////////////////////////

    function automatic bit reached(int what, int target);
        case (what)
            0: return busy === 1'b0;
            1: return out_valid === 1'b1;
            2: return wr_cnt >= target;
            default: return first_seen;
        endcase
    endfunction

    task automatic wait_until(input int what, input int target, output bit ok);
        int n;
        string wait_names [4] = '{"busy to fall", "out_valid", "WRITE on the pins",
                                  "the first pin command"};
        n  = 0;
        ok = reached(what, target);
        while (!ok && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
            ok = reached(what, target);
        end
        if (!ok) begin
            $display("timeout after %0d cycles waiting for %s", n, wait_names[what]);
            errors++;
        end
    endtask

    task automatic strobe(bit write, addr_t addr, data_t data);
        in_valid  = 1'b1;
        rw        = write;
        user_addr = addr;
        data_in   = data;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    initial begin : stimulus
        int    i;
        int    tests_run;
        int    tests_ok;
        int    test_err0;
        int    test_wr0;
        int    test_ref0;
        int    test_writes;
        int    a0;
        int    p0;
        int    r0;
        int    w0;
        bit    ok;
        step_t s;
        data_t exp;
        data_t rnd_word;
        integer seed;

        seed      = 32'h29d1_fa55;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        sdram_dqi = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // init: mode register load, then the queue opens
        wait_until(0, 0, ok);
        // the load reaches the model one cycle after the pins change
        wait_until(3, 0, ok);
        assert (first_seen && first_cmd == CMD_LOAD_MODE) else begin
            $display("mismatch pins command: got %h, expected %h", first_cmd, CMD_LOAD_MODE);
            errors++;
        end
        assert (first_addr === MODE_WORD) else begin
            $display("mismatch pins.addr: got %h, expected %h", first_addr, MODE_WORD);
            errors++;
        end
        tests_run = 1;
        tests_ok  = (errors == 0);
        $display("test 1 %s: %s", names[1], errors == 0 ? "ok" : "FAIL");

        steps.push_back(make_step(2, 1, 0, 0, make_addr(5, 1, 3), 32'hcafe_0001));
        steps.push_back(make_step(2, 0, expect_hit, 0, make_addr(5, 1, 3), 0));
        steps.push_back(make_step(3, 1, 0, 0, make_addr(7, 2, 10), 32'h0707_a0a0));
        steps.push_back(make_step(3, 1, expect_miss, 0, make_addr(9, 2, 10), 32'h0909_b0b0));
        steps.push_back(make_step(3, 0, expect_miss, 0, make_addr(7, 2, 10), 0));
        steps.push_back(make_step(3, 0, expect_miss, 0, make_addr(9, 2, 10), 0));
        steps.push_back(make_step(4, 0, 0, 130, make_addr(9, 2, 10), 0));
        steps.push_back(make_step(4, 0, expect_ref, 0, make_addr(5, 1, 3), 0));
        steps.push_back(make_step(5, 1, stray_strobe, 0, make_addr(3, 0, 32), 32'h1111_2222));
        steps.push_back(make_step(5, 0, 0, 0, make_addr(3, 0, 32), 0));
        for (i = 0; i < 14; i++) begin
            steps.push_back(make_step(6, (i % 3) != 2, rnd_addr, 0, '0, '0));
        end

        for (i = 0; i < steps.size(); i++) begin
            s = steps[i];
            if (i == 0 || steps[i-1].test != s.test) begin
                test_err0   = errors;
                test_wr0    = wr_cnt;
                test_ref0   = refresh_cnt;
                test_writes = 0;
            end
            if (s.gap != 0) begin
                repeat (s.gap) @(posedge clk);
                #1;
            end
            if (s.flags & rnd_addr) begin
                // small address set so reads often land on earlier writes
                rnd_word = $random(seed);
                s.addr   = make_addr(rnd_word[0], rnd_word[5:4], rnd_word[8]);
                s.data   = $random(seed);
            end
            wait_until(0, 0, ok);
            if (!ok) break;
            a0  = act_cnt;
            p0  = pre_cnt;
            r0  = refresh_cnt;
            w0  = wr_cnt;
            exp = expected_word(s.addr);
            strobe(s.write, s.addr, s.data);
            if (s.flags & stray_strobe) begin
                assert (busy === 1'b1) else begin
                    $display("busy did not rise after an accepted request");
                    errors++;
                end
                strobe(1'b1, s.addr, ~s.data);
            end
            if (s.write) begin
                shadow[s.addr] = s.data;
                test_writes++;
                wait_until(2, w0 + 1, ok);
            end else begin
                wait_until(1, 0, ok);
                if (ok) begin
                    assert (data_out === exp) else begin
                        $display("mismatch data_out at %h: got %h, expected %h",
                                 s.addr, data_out, exp);
                        errors++;
                    end
                end
            end
            if (!ok) break;
            if (s.flags & expect_hit) begin
                // a refresh in between closes the row, so an activate is fair then
                assert (act_cnt == a0 || refresh_cnt != r0) else begin
                    $display("row hit access issued an ACTIVATE");
                    errors++;
                end
            end
            if (s.flags & expect_miss) begin
                assert (pre_cnt != p0) else begin
                    $display("row miss access issued no PRECHARGE");
                    errors++;
                end
            end
            if (s.flags & expect_ref) begin
                assert (refresh_cnt != test_ref0) else begin
                    $display("no REFRESH seen during the long idle run");
                    errors++;
                end
            end
            if (i == steps.size() - 1 || steps[i+1].test != s.test) begin
                assert (wr_cnt - test_wr0 == test_writes) else begin
                    $display("mismatch WRITE count: got %0h, expected %0h",
                             wr_cnt - test_wr0, test_writes);
                    errors++;
                end
                tests_run++;
                if (errors == test_err0) tests_ok++;
                $display("test %0d %s: %s", s.test, names[s.test],
                         errors == test_err0 ? "ok" : "FAIL");
            end
        end

        $display("%0d of 6 tests run, %0d ok, %0d errors", tests_run, tests_ok, errors);
        if (errors == 0 && tests_run == 6) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
sdram_cfg_pkg.sv
sdram_cmd_pkg.sv
sdram_request_queue.sv
sdram_bank_tracker.sv
sdram_timer.sv
sdram_sequencer.sv
sdram_pin_driver.sv
sdram_ctrl_top.sv
sdram_ctrl_assertions.sv
tb_sdram_ctrl.sv
